//--- subsys_settings.svh
// Width, region, memory and core count settings for the memory/host subsystem
`ifndef SUBSYS_SETTINGS_SVH
`define SUBSYS_SETTINGS_SVH

// Wishbone bus widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define SEL_WIDTH 4

// Memory is 2**MEM_ADDR_BITS words
`define MEM_ADDR_BITS 10
`define MEM_LATENCY_CYCLES 3

// Cores reporting program finish
`define NUM_CORES 4

// Address bit 31 value for the host region, the other value selects memory
`define HOST_REGION_SEL 0

// Host address fields
`define HOST_REG_BITS 4
`define CORE_FIELD_BITS 2

`endif

//--- subsys_pkg.sv
// Wishbone request and response structs, address views, host register index
`include "subsys_settings.svh"

package subsys_pkg;

   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`ADDR_WIDTH-1:0] adr;
      logic [`DATA_WIDTH-1:0] dat;
      logic [`SEL_WIDTH-1:0]  sel;
   } wb_req_s;

   typedef struct packed {
      logic                   ack;
      logic [`DATA_WIDTH-1:0] dat;
   } wb_resp_s;

   typedef enum logic [`HOST_REG_BITS-1:0] {
      REG_PUTCHAR = 4'd0,
      REG_FINISH  = 4'd1
   } host_reg_e;

   // Memory view: region, unused, word index, byte offset
   typedef struct packed {
      logic                                     region;
      logic [`ADDR_WIDTH-`MEM_ADDR_BITS-4:0]    unused;
      logic [`MEM_ADDR_BITS-1:0]                word;
      logic [1:0]                               offset;
   } mem_addr_s;

   // Host view: region, unused, register, core, byte offset
   typedef struct packed {
      logic                                                      region;
      logic [`ADDR_WIDTH-`HOST_REG_BITS-`CORE_FIELD_BITS-4:0]    unused;
      host_reg_e                                                 reg_idx;
      logic [`CORE_FIELD_BITS-1:0]                               core;
      logic [1:0]                                                offset;
   } host_addr_s;

   typedef union packed {
      mem_addr_s  mem;
      host_addr_s host;
   } wb_addr_u;

endpackage

//--- wb_front.sv
// Wishbone classic request front end
// Captures one command, starts the selected target, registers ack and read data
`timescale 1ns/1ps
`include "subsys_settings.svh"

module wb_front
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  subsys_pkg::wb_req_s    wb_req_i,
   output subsys_pkg::wb_resp_s   wb_resp_o,
   output logic                   mem_start_o,
   output logic                   host_start_o,
   output subsys_pkg::wb_req_s    req_o,
   input  logic                   mem_done_i,
   input  logic [`DATA_WIDTH-1:0] mem_rdata_i,
   input  logic                   host_done_i,
   input  logic [`DATA_WIDTH-1:0] host_rdata_i
);
   import subsys_pkg::*;

   wb_req_s                req_q;
   wb_addr_u               addr_w;
   logic                   busy_q;
   logic                   cap_q;
   logic                   mem_start_q;
   logic                   host_start_q;
   logic                   ack_q;
   logic [`DATA_WIDTH-1:0] dat_q;
   logic                   capture_w;
   logic                   done_w;
   logic                   is_mem_w;

   // No new command while busy or while the master still sees ack
   assign capture_w = wb_req_i.cyc && wb_req_i.stb && !busy_q && !ack_q;
   assign done_w    = mem_done_i || host_done_i;

   assign addr_w   = req_q.adr;
   assign is_mem_w = (addr_w.mem.region != 1'(`HOST_REGION_SEL));

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         busy_q       <= 1'b0;
         cap_q        <= 1'b0;
         mem_start_q  <= 1'b0;
         host_start_q <= 1'b0;
         ack_q        <= 1'b0;
      end
      else
      begin
         cap_q        <= capture_w;
         mem_start_q  <= cap_q && is_mem_w;
         host_start_q <= cap_q && !is_mem_w;
         ack_q        <= done_w;
         if (capture_w)
            busy_q <= 1'b1;
         else if (done_w)
            busy_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (capture_w)
         req_q <= wb_req_i;
      if (mem_done_i)
         dat_q <= mem_rdata_i;
      else if (host_done_i)
         dat_q <= host_rdata_i;
   end

   assign mem_start_o   = mem_start_q;
   assign host_start_o  = host_start_q;
   assign req_o         = req_q;
   assign wb_resp_o.ack = ack_q;
   assign wb_resp_o.dat = dat_q;

endmodule

//--- mem_store.sv
// Word memory with byte-enable writes and a fixed-latency response
`timescale 1ns/1ps
`include "subsys_settings.svh"

module mem_store
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   start_i,
   input  subsys_pkg::wb_req_s    req_i,
   output logic                   done_o,
   output logic [`DATA_WIDTH-1:0] rdata_o
);
   import subsys_pkg::*;

   localparam int unsigned mem_depth = 1 << `MEM_ADDR_BITS;
   localparam int unsigned lat       = `MEM_LATENCY_CYCLES;

   logic [`DATA_WIDTH-1:0] mem_q [mem_depth];
   logic [`DATA_WIDTH-1:0] rdata_q;
   logic [lat-1:0]         lat_q;
   wb_addr_u               addr_w;
   logic                   wr_w;

   assign addr_w = req_i.adr;
   assign wr_w   = start_i && req_i.we;

   // Latency chain, one bit per cycle of response delay
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         lat_q <= '0;
      end
      else
      begin
         lat_q <= {lat_q[lat-2:0], start_i};
      end
   end

   // Byte lanes written under sel
   always_ff @(posedge clk_i)
   begin
      for (int b = 0; b < `SEL_WIDTH; b++)
      begin
         if (wr_w && req_i.sel[b])
            mem_q[addr_w.mem.word][8*b +: 8] <= req_i.dat[8*b +: 8];
      end
   end

   // Read word is sampled at start and held until done
   always_ff @(posedge clk_i)
   begin
      if (start_i)
         rdata_q <= mem_q[addr_w.mem.word];
   end

   assign done_o  = lat_q[lat-1];
   assign rdata_o = rdata_q;

endmodule

//--- host_regs.sv
// Host register block
// Console character output and per-core program finish flags
`timescale 1ns/1ps
`include "subsys_settings.svh"

module host_regs
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   start_i,
   input  subsys_pkg::wb_req_s    req_i,
   output logic                   done_o,
   output logic [`DATA_WIDTH-1:0] rdata_o,
   output logic                   putchar_v_o,
   output logic [7:0]             putchar_o,
   output logic [`NUM_CORES-1:0]  finish_o,
   output logic                   all_finish_o
);
   import subsys_pkg::*;

   wb_addr_u               addr_w;
   logic                   done_q;
   logic                   putchar_v_q;
   logic [7:0]             putchar_q;
   logic [`NUM_CORES-1:0]  finish_q;
   logic                   all_finish_q;
   logic [`DATA_WIDTH-1:0] rdata_q;
   logic                   put_wr_w;
   logic                   fin_wr_w;

   assign addr_w   = req_i.adr;
   assign put_wr_w = start_i && req_i.we && (addr_w.host.reg_idx == REG_PUTCHAR);
   assign fin_wr_w = start_i && req_i.we && (addr_w.host.reg_idx == REG_FINISH);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         done_q       <= 1'b0;
         putchar_v_q  <= 1'b0;
         finish_q     <= '0;
         all_finish_q <= 1'b0;
      end
      else
      begin
         done_q       <= start_i;
         putchar_v_q  <= put_wr_w;
         all_finish_q <= &finish_q;
         // Core field picks the flag, data bit 0 sets or clears it
         if (fin_wr_w)
            finish_q[addr_w.host.core] <= req_i.dat[0];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (put_wr_w)
         putchar_q <= req_i.dat[7:0];
      if (start_i)
      begin
         if (addr_w.host.reg_idx == REG_FINISH)
            rdata_q <= `DATA_WIDTH'(finish_q);
         else
            rdata_q <= '0;
      end
   end

   assign done_o       = done_q;
   assign rdata_o      = rdata_q;
   assign putchar_v_o  = putchar_v_q;
   assign putchar_o    = putchar_q;
   assign finish_o     = finish_q;
   assign all_finish_o = all_finish_q;

endmodule

//--- mem_host_top.sv
// Memory and host I/O subsystem behind one Wishbone classic slave port
`timescale 1ns/1ps
`include "subsys_settings.svh"

module mem_host_top
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  subsys_pkg::wb_req_s   wb_req_i,
   output subsys_pkg::wb_resp_s  wb_resp_o,
   output logic                  putchar_v_o,
   output logic [7:0]            putchar_o,
   output logic [`NUM_CORES-1:0] finish_o,
   output logic                  all_finish_o
);
   import subsys_pkg::*;

   wb_req_s                req_w;
   logic                   mem_start_w;
   logic                   host_start_w;
   logic                   mem_done_w;
   logic                   host_done_w;
   logic [`DATA_WIDTH-1:0] mem_rdata_w;
   logic [`DATA_WIDTH-1:0] host_rdata_w;

   wb_front i_front
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .wb_req_i     (wb_req_i),
      .wb_resp_o    (wb_resp_o),
      .mem_start_o  (mem_start_w),
      .host_start_o (host_start_w),
      .req_o        (req_w),
      .mem_done_i   (mem_done_w),
      .mem_rdata_i  (mem_rdata_w),
      .host_done_i  (host_done_w),
      .host_rdata_i (host_rdata_w)
   );

   mem_store i_mem
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .start_i (mem_start_w),
      .req_i   (req_w),
      .done_o  (mem_done_w),
      .rdata_o (mem_rdata_w)
   );

   host_regs i_host
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (host_start_w),
      .req_i        (req_w),
      .done_o       (host_done_w),
      .rdata_o      (host_rdata_w),
      .putchar_v_o  (putchar_v_o),
      .putchar_o    (putchar_o),
      .finish_o     (finish_o),
      .all_finish_o (all_finish_o)
   );

endmodule

//--- tb_mem_host.sv
// Testbench for the memory and host I/O subsystem
// Stimulus table built from a reference model, applied in a loop
`timescale 1ns/1ps
`include "subsys_settings.svh"

module tb_mem_host;
   import subsys_pkg::*;

   localparam int clk_period   = 8;
   localparam int mem_ack_lat  = `MEM_LATENCY_CYCLES + 2;
   localparam int host_ack_lat = 3;
   localparam int max_wait     = 20;

   typedef struct packed {
      logic                   we;
      logic [`ADDR_WIDTH-1:0] adr;
      logic [`DATA_WIDTH-1:0] dat;
      logic [`SEL_WIDTH-1:0]  sel;
      logic [`DATA_WIDTH-1:0] exp_dat;
      logic                   exp_put;
      logic [7:0]             exp_char;
      logic [`NUM_CORES-1:0]  exp_finish;
   } entry_s;

   logic                   clk_i;
   logic                   reset_i;
   wb_req_s                wb_req;
   wb_resp_s               wb_resp;
   logic                   putchar_v;
   logic [7:0]             putchar;
   logic [`NUM_CORES-1:0]  finish;
   logic                   all_finish;
   entry_s                 stim_q [$];
   logic [`DATA_WIDTH-1:0] ref_mem [1 << `MEM_ADDR_BITS];
   logic [`NUM_CORES-1:0]  ref_finish;
   int                     test_errors;
   int                     tests_run;
   int                     tests_failed;

   mem_host_top i_dut
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .wb_req_i     (wb_req),
      .wb_resp_o    (wb_resp),
      .putchar_v_o  (putchar_v),
      .putchar_o    (putchar),
      .finish_o     (finish),
      .all_finish_o (all_finish)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(clk_period / 2) clk_i = ~clk_i;
   end

   task automatic check_equal(input string sig, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("error: %s expected 0x%0h got 0x%0h", sig, exp, got);
         test_errors++;
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      assert (ok)
      else
      begin
         $display("%s", what);
         test_errors++;
      end
   endtask

   function automatic logic [`ADDR_WIDTH-1:0] mem_addr(input logic [`MEM_ADDR_BITS-1:0] word);
      return {~1'(`HOST_REGION_SEL), {(`ADDR_WIDTH-`MEM_ADDR_BITS-3){1'b0}}, word, 2'b00};
   endfunction

   function automatic logic [`ADDR_WIDTH-1:0] host_addr(input host_reg_e sel_reg,
                                                        input logic [1:0] core);
      return {1'(`HOST_REGION_SEL), {(`ADDR_WIDTH-`HOST_REG_BITS-5){1'b0}},
              sel_reg, core, 2'b00};
   endfunction

   // Expected values follow the region and register rules
   task automatic add_entry(input logic we, input logic [`ADDR_WIDTH-1:0] adr,
                            input logic [`DATA_WIDTH-1:0] dat, input logic [3:0] sel);
      entry_s                 e;
      logic [`DATA_WIDTH-1:0] mask;
      logic [9:0]             word;
      e    = '0;
      e.we = we;
      e.adr = adr;
      e.dat = dat;
      e.sel = sel;
      word = adr[11:2];
      if (adr[`ADDR_WIDTH-1] != 1'(`HOST_REGION_SEL))
      begin
         // Unselected byte lanes keep their old value
         for (int b = 0; b < `SEL_WIDTH; b++)
            mask[8*b +: 8] = {8{sel[b]}};
         if (we)
            ref_mem[word] = (ref_mem[word] & ~mask) | (dat & mask);
         e.exp_dat = ref_mem[word];
      end
      else if (adr[7:4] == REG_PUTCHAR)
      begin
         e.exp_put  = we;
         e.exp_char = dat[7:0];
      end
      else if (we)
         ref_finish[adr[3:2]] = dat[0];
      else
         e.exp_dat = 32'(ref_finish);
      e.exp_finish = ref_finish;
      stim_q.push_back(e);
   endtask

   task automatic finish_test(input string label);
      $display("test %0d %s: %s", tests_run, label, (test_errors == 0) ? "ok" : "FAILED");
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      test_errors = 0;
   endtask

   task automatic run_command(input entry_s e);
      int cycles;
      int puts;
      int exp_lat;
      logic got;
      got     = 1'b0;
      cycles  = 0;
      puts    = 0;
      exp_lat = (e.adr[`ADDR_WIDTH-1] == 1'(`HOST_REGION_SEL)) ? host_ack_lat : mem_ack_lat;
      @(negedge clk_i);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: e.we, adr: e.adr, dat: e.dat, sel: e.sel};
      // Capture edge, cycles count from here
      @(posedge clk_i);
      while (!got && cycles < max_wait)
      begin
         @(negedge clk_i);
         if (putchar_v)
         begin
            puts++;
            check_equal("putchar_o", 32'(putchar), 32'(e.exp_char));
         end
         if (wb_resp.ack)
         begin
            got = 1'b1;
            check_true(cycles == exp_lat, $sformatf("ack came after %0d cycles, not %0d",
                                                    cycles, exp_lat));
            if (!e.we)
               check_equal("wb_resp_o.dat", wb_resp.dat, e.exp_dat);
         end
         cycles++;
      end
      check_true(got, $sformatf("no ack within %0d cycles", max_wait));
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      @(negedge clk_i);
      check_true(!wb_resp.ack, "ack stayed high for more than one cycle");
      if (putchar_v)
         puts++;
      check_true(puts == int'(e.exp_put), $sformatf("putchar_v_o pulsed %0d times", puts));
      check_equal("finish_o", 32'(finish), 32'(e.exp_finish));
      check_equal("all_finish_o", 32'(all_finish), 32'(&e.exp_finish));
   endtask

   initial
   begin
      reset_i      = 1'b1;
      wb_req       = '0;
      ref_finish   = '0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(51400));
      add_entry(1'b1, mem_addr(10'd5), $urandom, 4'hf);
      add_entry(1'b0, mem_addr(10'd5), '0, 4'hf);
      add_entry(1'b1, mem_addr(10'd1023), $urandom, 4'hf);
      add_entry(1'b1, mem_addr(10'd5), $urandom, 4'h5);
      add_entry(1'b0, mem_addr(10'd5), '0, 4'hf);
      add_entry(1'b0, mem_addr(10'd1023), '0, 4'hf);
      add_entry(1'b1, mem_addr(10'd200), $urandom, 4'hf);
      add_entry(1'b1, mem_addr(10'd200), $urandom, 4'h8);
      add_entry(1'b0, mem_addr(10'd200), '0, 4'hf);
      add_entry(1'b1, host_addr(REG_PUTCHAR, 2'd0), $urandom, 4'hf);
      add_entry(1'b1, host_addr(REG_PUTCHAR, 2'd0), $urandom, 4'hf);
      add_entry(1'b1, host_addr(REG_FINISH, 2'd0), 32'h1, 4'hf);
      add_entry(1'b1, host_addr(REG_FINISH, 2'd2), $urandom | 32'h1, 4'hf);
      add_entry(1'b0, host_addr(REG_FINISH, 2'd0), '0, 4'hf);
      add_entry(1'b1, host_addr(REG_FINISH, 2'd1), 32'h1, 4'hf);
      add_entry(1'b1, host_addr(REG_FINISH, 2'd3), $urandom | 32'h1, 4'hf);
      add_entry(1'b0, host_addr(REG_FINISH, 2'd0), '0, 4'hf);
      add_entry(1'b1, host_addr(REG_FINISH, 2'd2), $urandom & 32'hffff_fffe, 4'hf);
      add_entry(1'b0, host_addr(REG_FINISH, 2'd0), '0, 4'hf);
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      check_equal("wb_resp_o.ack", 32'(wb_resp.ack), 32'h0);
      check_equal("putchar_v_o", 32'(putchar_v), 32'h0);
      check_equal("finish_o", 32'(finish), 32'h0);
      check_equal("all_finish_o", 32'(all_finish), 32'h0);
      finish_test("reset state");
      foreach (stim_q[i])
      begin
         run_command(stim_q[i]);
         finish_test($sformatf("%s %s adr 0x%08h",
                               (stim_q[i].adr[`ADDR_WIDTH-1] == 1'(`HOST_REGION_SEL)) ?
                               "host" : "memory", stim_q[i].we ? "write" : "read",
                               stim_q[i].adr));
      end
      $display("%0d tests run, %0d failed", tests_run, tests_failed);
      if (tests_failed == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Run limit from the table length
   initial
   begin
      int limit;
      #1;
      limit = (stim_q.size() + 1) * 10 * clk_period + 100;
      #(limit);
      $display("watchdog ended the run after %0d ns", limit);
      $display("Something failed");
      $finish;
   end

endmodule

//--- list.f
+incdir+.
subsys_pkg.sv
wb_front.sv
mem_store.sv
host_regs.sv
mem_host_top.sv
tb_mem_host.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module tb_mem_host --Mdir obj_dir
	@out="$$(./obj_dir/Vtb_mem_host)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
